/* hdl/fcvt_defs.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// width and exponent bias macros for the
// integer to float conversion unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FCVT_DEFS_SVH
`define FCVT_DEFS_SVH

// datapath widths
`define FCVT_INT_W 64
`define FCVT_RES_W 80
`define FCVT_TAG_W 4
`define FCVT_CNT_W 16

// IEEE exponent biases per target format
`define FCVT_BIAS_SNG 127
`define FCVT_BIAS_DBL 1023
`define FCVT_BIAS_EXT 16383

`endif

/* hdl/fcvtPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// types for the conversion unit: vectors, format
// enum, request, response and config structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "fcvt_defs.svh"

package fcvtPkg;

  typedef logic [`FCVT_INT_W-1:0] intOp_t;
  // single in [31:0], double in [63:0], extended uses all 80
  typedef logic [`FCVT_RES_W-1:0] fpRes_t;
  typedef logic [`FCVT_TAG_W-1:0] tag_t;
  typedef logic [`FCVT_CNT_W-1:0] convCnt_t;
  // bit position of the leading one
  typedef logic [$clog2(`FCVT_INT_W)-1:0] expIdx_t;

  // code 2'd3 is unused
  typedef enum logic [1:0] {
    FMT_SNG = 2'd0,
    FMT_DBL = 2'd1,
    FMT_EXT = 2'd2
  } fpFmt_e;

  typedef struct packed {
    fpFmt_e fmt;
    logic   isSigned;
  } cvtCfg_t;

  typedef struct packed {
    tag_t   tag;
    intOp_t operand;
  } cvtReq_t;

  typedef struct packed {
    tag_t   tag;
    fpFmt_e fmt;
    fpRes_t result;
  } cvtRsp_t;

endpackage

/* hdl/leadOneFind.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// leadOneFind: priority encoder for the highest set bit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module leadOneFind #(
  parameter int WIDTH = 64
) (
  input  logic [WIDTH-1:0]         vec,
  output logic [$clog2(WIDTH)-1:0] idx,
  output logic                     found
);

  localparam int IdxW = $clog2(WIDTH);

  // ascending scan, so the last hit is the most significant one
  always_comb begin
    idx = '0;
    for (int i = 0; i < WIDTH; i++) begin
      if (vec[i]) begin
        idx = i[IdxW-1:0];
      end
    end
  end

  // idx stays 0 on an empty vector, found tells it apart from bit 0
  assign found = |vec;

endmodule

/* hdl/intToFloat.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// intToFloat: two-stage integer to single, double
// or extended conversion, truncating toward zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fcvt_defs.svh"

module intToFloat (
  input  logic             clk,
  input  logic             arstN,
  input  logic             advance,
  input  logic             reqValid,
  input  fcvtPkg::cvtReq_t req,
  input  fcvtPkg::cvtCfg_t cfg,
  output logic             rspValid,
  output fcvtPkg::cvtRsp_t rsp
);

  import fcvtPkg::*;

  localparam int BiasSng = `FCVT_BIAS_SNG;
  localparam int BiasDbl = `FCVT_BIAS_DBL;
  localparam int BiasExt = `FCVT_BIAS_EXT;

  // stage 1 input side
  logic    negIn;
  intOp_t  magIn;

  // stage 1 registers
  logic    s1Valid;
  intOp_t  s1Mag;
  logic    s1Sign;
  fpFmt_e  s1Fmt;
  tag_t    s1Tag;

  // leading one search on stage 1
  logic [7:0] byteAny;
  logic [2:0] byteIdx;
  logic [7:0] leadByte;
  logic [2:0] bitIdx;
  logic       bitFound;
  expIdx_t    leadIdx;
  intOp_t     normMag;

  // stage 2 registers
  logic    s2Valid;
  intOp_t  s2Mant;
  expIdx_t s2Idx;
  logic    s2Found;
  logic    s2Sign;
  fpFmt_e  s2Fmt;
  tag_t    s2Tag;

  // output packing
  logic [7:0]  expSng;
  logic [10:0] expDbl;
  logic [14:0] expExt;
  fpRes_t      fpField;

  // magnitude by conditional negation
  assign negIn = cfg.isSigned && req.operand[63];
  assign magIn = negIn ? -req.operand : req.operand;

  // one OR bit per byte, then search the winning byte
  always_comb begin
    for (int b = 0; b < 8; b++) begin
      byteAny[b] = |s1Mag[b*8 +: 8];
    end
  end

  // a zero operand selects byte 0, so bitFound alone covers it
  leadOneFind #(.WIDTH(8)) u_byteFind (
    .vec   (byteAny),
    .idx   (byteIdx),
    .found ()
  );

  assign leadByte = s1Mag[{byteIdx, 3'b000} +: 8];

  leadOneFind #(.WIDTH(8)) u_bitFind (
    .vec   (leadByte),
    .idx   (bitIdx),
    .found (bitFound)
  );

  assign leadIdx = {byteIdx, bitIdx};
  // 63 - leadIdx is just the inverse of the 6-bit index
  assign normMag = s1Mag << (~leadIdx);

  // valid bits
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      s1Valid <= 1'b0;
      s2Valid <= 1'b0;
    end else if (advance) begin
      s1Valid <= reqValid;
      s2Valid <= s1Valid;
    end
  end

  // payload, frozen together with the valids
  always_ff @(posedge clk) begin
    if (advance) begin
      s1Mag   <= magIn;
      s1Sign  <= negIn;
      s1Fmt   <= cfg.fmt;
      s1Tag   <= req.tag;
      s2Mant  <= normMag;
      s2Idx   <= leadIdx;
      s2Found <= bitFound;
      s2Sign  <= s1Sign;
      s2Fmt   <= s1Fmt;
      s2Tag   <= s1Tag;
    end
  end

  // biased exponents
  assign expSng = BiasSng[7:0] + {2'b00, s2Idx};
  assign expDbl = BiasDbl[10:0] + {5'b00000, s2Idx};
  assign expExt = BiasExt[14:0] + {9'b0, s2Idx};

  // hidden one dropped for single and double, explicit for extended
  always_comb begin
    fpField = '0;
    if (s2Found) begin
      case (s2Fmt)
        FMT_SNG: fpField = {48'b0, s2Sign, expSng, s2Mant[62:40]};
        FMT_DBL: fpField = {16'b0, s2Sign, expDbl, s2Mant[62:11]};
        FMT_EXT: fpField = {s2Sign, expExt, s2Mant};
        default: fpField = '0;
      endcase
    end
  end

  assign rspValid = s2Valid;
  assign rsp      = '{tag: s2Tag, fmt: s2Fmt, result: fpField};

  // format code travels from the config register through both stages
  aValidFmt : assert property (@(posedge clk) disable iff (!arstN)
    rspValid |-> rsp.fmt inside {FMT_SNG, FMT_DBL, FMT_EXT});

  // a stalled response holds until the output side takes it
  aStallHold : assert property (@(posedge clk) disable iff (!arstN)
    rspValid && !advance |=> rspValid && $stable(rsp));

endmodule

/* hdl/fcvtConfig.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fcvtConfig: format and signedness register,
// delivered result counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fcvtConfig (
  input  logic              clk,
  input  logic              arstN,
  input  logic              cfgWe,
  input  fcvtPkg::cvtCfg_t  cfgWdata,
  output fcvtPkg::cvtCfg_t  cfgRdata,
  output fcvtPkg::cvtCfg_t  cfg,
  input  logic              rspFire,
  output fcvtPkg::convCnt_t convCount
);

  import fcvtPkg::*;

  cvtCfg_t  cfgReg;
  logic     wrOk;
  convCnt_t cntReg;

  // unused format code is dropped, the register keeps its value
  assign wrOk = cfgWe && (cfgWdata.fmt inside {FMT_SNG, FMT_DBL, FMT_EXT});

  // comes up as signed to double
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cfgReg <= '{fmt: FMT_DBL, isSigned: 1'b1};
    end else if (wrOk) begin
      cfgReg <= cfgWdata;
    end
  end

  // wraps at the counter width
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cntReg <= '0;
    end else if (rspFire) begin
      cntReg <= cntReg + 1'b1;
    end
  end

  // the converter samples cfg on each accepted request
  assign cfg       = cfgReg;
  assign cfgRdata  = cfgReg;
  assign convCount = cntReg;

  aCfgFmt : assert property (@(posedge clk) disable iff (!arstN)
    cfgReg.fmt inside {FMT_SNG, FMT_DBL, FMT_EXT});

endmodule

/* hdl/fcvtTop.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fcvtTop: config block and converter behind a
// valid/ready request and response interface
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fcvtTop (
  input  logic              clk,
  input  logic              arstN,
  // request side
  input  logic              inValid,
  output logic              inReady,
  input  fcvtPkg::cvtReq_t  inReq,
  // response side
  output logic              outValid,
  input  logic              outReady,
  output fcvtPkg::cvtRsp_t  outRsp,
  // config port
  input  logic              cfgWe,
  input  fcvtPkg::cvtCfg_t  cfgWdata,
  output fcvtPkg::cvtCfg_t  cfgRdata,
  output fcvtPkg::convCnt_t convCount
);

  import fcvtPkg::*;

  cvtCfg_t cfg;
  logic    advance;
  logic    rspFire;

  // whole pipeline moves unless a response sits unaccepted
  assign advance = !outValid || outReady;
  assign rspFire = outValid && outReady;
  assign inReady = advance;

  fcvtConfig u_fcvtConfig (
    .clk       (clk),
    .arstN     (arstN),
    .cfgWe     (cfgWe),
    .cfgWdata  (cfgWdata),
    .cfgRdata  (cfgRdata),
    .cfg       (cfg),
    .rspFire   (rspFire),
    .convCount (convCount)
  );

  // inValid is qualified by advance inside, since reqValid is only
  // sampled when the stages move
  intToFloat u_intToFloat (
    .clk      (clk),
    .arstN    (arstN),
    .advance  (advance),
    .reqValid (inValid),
    .req      (inReq),
    .cfg      (cfg),
    .rspValid (outValid),
    .rsp      (outRsp)
  );

endmodule

/* tb/fcvtChecker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model, expected queue and port
// checks for the conversion unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fcvt_defs.svh"

module fcvtChecker (
  input  logic              clk,
  input  logic              arstN,
  input  logic              inValid,
  input  logic              inReady,
  input  fcvtPkg::cvtReq_t  inReq,
  input  logic              outValid,
  input  logic              outReady,
  input  fcvtPkg::cvtRsp_t  outRsp,
  input  logic              cfgWe,
  input  fcvtPkg::cvtCfg_t  cfgWdata,
  input  fcvtPkg::cvtCfg_t  cfgRdata,
  input  fcvtPkg::convCnt_t convCount,
  input  logic              latencyChk,
  output int                errCount,
  output int                pending
);

  import fcvtPkg::*;

  string   testName = "none";
  int      errTotal = 0;
  int      pendCnt = 0;
  cvtCfg_t shadow;
  cvtRsp_t expQ[$];
  int      acceptQ[$];
  int      cycle;
  int      xferCount;
  logic    wasStalled;
  cvtRsp_t heldRsp;
  cvtRsp_t expRsp;
  int      acceptAt;

  assign errCount = errTotal;
  assign pending  = pendCnt;

  task automatic setTest(input string name);
    testName = name;
  endtask

  task automatic reportValue(input string what, input logic [85:0] expV,
                             input logic [85:0] actV);
    $display("[ERROR] %s: %s expected %h actual %h", testName, what, expV, actV);
    errTotal++;
  endtask

  task automatic reportText(input string msg);
    $display("%s: %s", testName, msg);
    errTotal++;
  endtask

  // IEEE encoding with truncation toward zero
  function automatic fpRes_t expectResult(input intOp_t op, input fpFmt_e fmt,
                                          input logic sgn);
    logic   neg;
    intOp_t mag;
    intOp_t norm;
    int     msb;
    fpRes_t r;
    neg = sgn && op[63];
    mag = neg ? (~op + 64'd1) : op;
    r = '0;
    if (mag != '0) begin
      msb = 63;
      while (!mag[msb]) begin
        msb--;
      end
      norm = mag << (63 - msb);
      case (fmt)
        FMT_SNG: r = {48'b0, neg, 8'(`FCVT_BIAS_SNG + msb), norm[62:40]};
        FMT_DBL: r = {16'b0, neg, 11'(`FCVT_BIAS_DBL + msb), norm[62:11]};
        FMT_EXT: r = {neg, 15'(`FCVT_BIAS_EXT + msb), norm};
        default: r = '0;
      endcase
    end
    return r;
  endfunction

  task automatic checkResetState();
    if (outValid !== 1'b0) begin
      reportText("outValid is high after reset");
    end
    if (inReady !== 1'b1) begin
      reportText("inReady is low after reset");
    end
    if (cfgRdata !== cvtCfg_t'({FMT_DBL, 1'b1})) begin
      reportValue("cfgRdata", {83'b0, FMT_DBL, 1'b1}, {83'b0, cfgRdata});
    end
    if (convCount !== '0) begin
      reportValue("convCount", '0, {70'b0, convCount});
    end
  endtask

  task automatic checkFinalCount();
    if (convCount !== convCnt_t'(xferCount)) begin
      reportValue("final convCount", 86'(xferCount), {70'b0, convCount});
    end
  endtask

  // sampled mid-cycle, so every value here applies to the next rising edge
  always @(negedge clk) begin
    if (!arstN) begin
      shadow = '{fmt: FMT_DBL, isSigned: 1'b1};
      expQ.delete();
      acceptQ.delete();
      cycle = 0;
      xferCount = 0;
      wasStalled = 1'b0;
    end else begin
      cycle++;
      if (convCount !== convCnt_t'(xferCount)) begin
        reportValue("convCount", 86'(xferCount), {70'b0, convCount});
      end
      if (cfgRdata !== shadow) begin
        reportValue("cfgRdata", {83'b0, shadow}, {83'b0, cfgRdata});
      end
      if (wasStalled) begin
        if (!outValid) begin
          reportText("outValid dropped while the response was stalled");
        end else if (outRsp !== heldRsp) begin
          reportValue("stalled outRsp", heldRsp, outRsp);
        end
      end
      // input side follows the output stall
      if (outValid && !outReady && inReady !== 1'b0) begin
        reportText("inReady is high while the response is stalled");
      end
      if (outReady && inReady !== 1'b1) begin
        reportText("inReady is low while outReady is high");
      end
      wasStalled = outValid && !outReady;
      heldRsp = outRsp;
      if (outValid && outReady) begin
        xferCount++;
        if (expQ.size() == 0) begin
          reportText("a response arrived with no request outstanding");
        end else begin
          expRsp = expQ.pop_front();
          acceptAt = acceptQ.pop_front();
          if (outRsp !== expRsp) begin
            reportValue("outRsp", expRsp, outRsp);
          end
          if (latencyChk && (cycle - acceptAt != 2)) begin
            reportValue("latency", 86'(2), 86'(cycle - acceptAt));
          end
        end
      end
      // a request takes the config from before a write on the same edge
      if (inValid && inReady) begin
        expRsp = '{tag: inReq.tag, fmt: shadow.fmt,
                   result: expectResult(inReq.operand, shadow.fmt, shadow.isSigned)};
        expQ.push_back(expRsp);
        acceptQ.push_back(cycle);
      end
      if (cfgWe && cfgWdata.fmt != 2'd3) begin
        shadow = cfgWdata;
      end
      pendCnt = expQ.size();
    end
  end

endmodule

/* tb/tbTop.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clock, reset, random stimulus and test
// sequence around the conversion unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tbTop;

  import fcvtPkg::*;

  logic     clk = 1'b0;
  logic     arstN;
  logic     inValid;
  logic     inReady;
  cvtReq_t  inReq;
  logic     outValid;
  logic     outReady;
  cvtRsp_t  outRsp;
  logic     cfgWe;
  cvtCfg_t  cfgWdata;
  cvtCfg_t  cfgRdata;
  convCnt_t convCount;
  logic     latencyChk;
  int       errCount;
  int       pending;

  logic [31:0] seed = 32'h16ee_ba0d;
  int          testsPassed = 0;
  int          testsFailed = 0;
  int          errBefore = 0;

  always #2 clk = ~clk;

  fcvtTop u_fcvtTop (
    .clk       (clk),
    .arstN     (arstN),
    .inValid   (inValid),
    .inReady   (inReady),
    .inReq     (inReq),
    .outValid  (outValid),
    .outReady  (outReady),
    .outRsp    (outRsp),
    .cfgWe     (cfgWe),
    .cfgWdata  (cfgWdata),
    .cfgRdata  (cfgRdata),
    .convCount (convCount)
  );

  fcvtChecker u_checker (
    .clk        (clk),
    .arstN      (arstN),
    .inValid    (inValid),
    .inReady    (inReady),
    .inReq      (inReq),
    .outValid   (outValid),
    .outReady   (outReady),
    .outRsp     (outRsp),
    .cfgWe      (cfgWe),
    .cfgWdata   (cfgWdata),
    .cfgRdata   (cfgRdata),
    .convCount  (convCount),
    .latencyChk (latencyChk),
    .errCount   (errCount),
    .pending    (pending)
  );

  function logic [31:0] nextRandom();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // upper LCG bits since the low ones repeat quickly
  function int percent();
    return int'((nextRandom() >> 16) % 32'd100);
  endfunction

  // first five of each burst are the corner values
  function intOp_t pickOperand(input int idx);
    logic [31:0] hi;
    int          sel;
    sel = (idx < 5) ? idx : percent();
    case (sel)
      0: return '0;
      1: return 64'd1;
      2: return '1;
      3: return 64'h8000_0000_0000_0000;
      4: return 64'd1 << (nextRandom() >> 26);
      default: begin
        hi = nextRandom();
        return {hi, nextRandom()};
      end
    endcase
  endfunction

  task automatic abortRun(input string msg);
    $display("timeout: %s", msg);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic startTest(input string name);
    u_checker.setTest(name);
    errBefore = errCount;
  endtask

  task automatic endTest(input string name);
    if (errCount == errBefore) begin
      $display("test %s: PASS", name);
      testsPassed++;
    end else begin
      $display("test %s: FAIL with %0d errors", name, errCount - errBefore);
      testsFailed++;
    end
  endtask

  // entered and left just after a rising edge
  task automatic writeConfig(input logic [1:0] fmtCode, input logic sgn);
    cfgWe = 1'b1;
    cfgWdata = '{fmt: fpFmt_e'(fmtCode), isSigned: sgn};
    @(posedge clk);
    #0.5;
    cfgWe = 1'b0;
  endtask

  task automatic runBurst(input int count, input int inDuty, input int outDuty,
                          input bit midCfg);
    int          sent;
    int          cycles;
    int          idx;
    bit          took;
    logic [31:0] r;
    sent = 0;
    cycles = 0;
    idx = 0;
    inValid = 1'b0;
    while (sent < count) begin
      @(negedge clk);
      took = inValid && inReady;
      @(posedge clk);
      #0.5;
      cycles++;
      if (took) begin
        sent++;
      end
      if (cycles > count * 20 + 100) begin
        abortRun("requests were not accepted in time");
      end
      // hold a pending request until it is taken
      if (took || !inValid) begin
        if (sent < count && percent() < inDuty) begin
          inValid = 1'b1;
          inReq = '{tag: tag_t'(idx), operand: pickOperand(idx)};
          idx++;
        end else begin
          inValid = 1'b0;
        end
      end
      outReady = percent() < outDuty;
      if (midCfg && percent() < 10) begin
        r = nextRandom();
        cfgWe = 1'b1;
        cfgWdata = '{fmt: fpFmt_e'(r[17:16]), isSigned: r[20]};
      end else begin
        cfgWe = 1'b0;
      end
    end
    inValid = 1'b0;
    cfgWe = 1'b0;
  endtask

  task automatic drain();
    int i;
    outReady = 1'b1;
    for (i = 0; i < 200 && pending != 0; i++) begin
      @(posedge clk);
    end
    if (pending != 0) begin
      abortRun("responses still outstanding after the drain limit");
    end
    @(posedge clk);
    #0.5;
  endtask

  task automatic runPhase(input string name, input logic [1:0] fmtCode, input logic sgn,
                          input int count, input int inDuty, input int outDuty,
                          input bit midCfg);
    startTest(name);
    writeConfig(fmtCode, sgn);
    runBurst(count, inDuty, outDuty, midCfg);
    drain();
    endTest(name);
  endtask

  initial begin
    arstN = 1'b0;
    inValid = 1'b0;
    inReq = '0;
    outReady = 1'b0;
    cfgWe = 1'b0;
    cfgWdata = '0;
    latencyChk = 1'b0;
    repeat (3) @(posedge clk);
    #0.5;
    arstN = 1'b1;

    startTest("reset_state");
    @(negedge clk);
    u_checker.checkResetState();
    @(posedge clk);
    #0.5;
    endTest("reset_state");

    runPhase("signed_sng", 2'd0, 1'b1, 40, 70, 100, 1'b0);
    runPhase("signed_dbl", 2'd1, 1'b1, 40, 70, 100, 1'b0);
    runPhase("signed_ext", 2'd2, 1'b1, 40, 70, 100, 1'b0);
    runPhase("unsigned_dbl", 2'd1, 1'b0, 40, 70, 100, 1'b0);
    runPhase("unsigned_ext", 2'd2, 1'b0, 40, 70, 100, 1'b0);
    runPhase("back_pressure", 2'd0, 1'b1, 80, 70, 70, 1'b0);
    runPhase("midstream_cfg", 2'd2, 1'b1, 80, 70, 70, 1'b1);

    // unused format code must leave the register alone
    runPhase("unused_fmt", 2'd3, 1'b0, 10, 70, 100, 1'b0);

    latencyChk = 1'b1;
    runPhase("latency", 2'd1, 1'b1, 40, 100, 100, 1'b0);
    latencyChk = 1'b0;

    startTest("final_count");
    u_checker.checkFinalCount();
    @(posedge clk);
    #0.5;
    endTest("final_count");

    $display("tests passed %0d, failed %0d, errors %0d",
             testsPassed, testsFailed, errCount);
    if (testsFailed == 0 && errCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+hdl
hdl/fcvtPkg.sv
hdl/leadOneFind.sv
hdl/intToFloat.sv
hdl/fcvtConfig.sv
hdl/fcvtTop.sv
tb/fcvtChecker.sv
tb/tbTop.sv

/* run.sh */
#!/bin/sh
# build and run the conversion unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f flist.f --top-module tbTop -o simv
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation completed successfully"; then
  exit 0
else
  exit 1
fi
